/* icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

////////////////////////////////////////
// cache geometry

// two ways per set
`define ICACHE_WAYS 2

`define ICACHE_SETS 128
`define ICACHE_TAG_W 20
`define ICACHE_INDEX_W 7

////////////////////////////////////////
// refill burst

// 4-byte beats per 32-byte line
`define ICACHE_BEATS 8

// one set invalidated per cycle
`define ICACHE_RESET_CYCLES `ICACHE_SETS

`endif

/* icache_pkg.sv */
`include "icache_settings.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    // AXI data bus word
    typedef logic [31:0] word_t;

    typedef logic [`ICACHE_BEATS*32-1:0] line_t;

    // returned to the CPU per request
    typedef logic [`ICACHE_BEATS*16-1:0] half_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // controller states
    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        RUN,
        MISS,
        REFILL,
        FINISH
    } cache_state_t;

endpackage

/* way_ram.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module way_ram #(
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               we,
    input  icache_pkg::index_t addr,
    input  payload_t           wdata,
    output payload_t           rdata
);

    payload_t mem [`ICACHE_SETS];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* tag_lookup.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module tag_lookup (
    input  logic                    clk,
    input  logic                    rst,
    input  icache_pkg::index_t      index,
    input  logic [`ICACHE_WAYS-1:0] we,
    input  icache_pkg::tag_t        wtag,
    input  logic                    wvalid,
    input  icache_pkg::tag_t        cmp_tag,
    input  logic                    cmp_en,
    output logic [`ICACHE_WAYS-1:0] hit_way
);
    import icache_pkg::*;

    tagv_t                   entry [`ICACHE_WAYS];
    tagv_t                   wentry;
    logic [`ICACHE_WAYS-1:0] match;

    // sweep writes valid low, refill writes valid high
    assign wentry = '{tag: wtag, valid: wvalid};

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        way_ram #(
            .payload_t(tagv_t)
        ) u_tagv (
            .clk  (clk),
            .we   (we[w]),
            .addr (index),
            .wdata(wentry),
            .rdata(entry[w])
        );

        // read entry stays on the ram output until the next read
        assign match[w] = entry[w].valid && (entry[w].tag == cmp_tag);
    end

    ////////////////////////////////////////
    // hit register for the data stage

    always_ff @(posedge clk) begin
        if (!rst) begin
            hit_way <= '0;
        end else if (cmp_en) begin
            hit_way <= match;
        end
    end

endmodule

/* data_lookup.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module data_lookup (
    input  logic                    clk,
    input  icache_pkg::index_t      index,
    input  logic [`ICACHE_WAYS-1:0] we,
    input  icache_pkg::line_t       wline,
    input  logic                    hold,
    output icache_pkg::line_t       line0,
    output icache_pkg::line_t       line1
);
    import icache_pkg::*;

    line_t ram_line [`ICACHE_WAYS];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        way_ram #(
            .payload_t(line_t)
        ) u_data (
            .clk  (clk),
            .we   (we[w]),
            .addr (index),
            .wdata(wline),
            .rdata(ram_line[w])
        );
    end

    ////////////////////////////////////////
    // data stage lines

    // frozen while the data stage waits
    always_ff @(posedge clk) begin
        if (!hold) begin
            line0 <= ram_line[0];
            line1 <= ram_line[1];
        end
    end

endmodule

/* refill_unit.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module refill_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  icache_pkg::word_t line_addr,
    output icache_pkg::word_t araddr,
    output logic              arvalid,
    input  logic              arready,
    input  icache_pkg::word_t rdata,
    input  logic              rvalid,
    input  logic              rlast,
    output logic              rready,
    output icache_pkg::line_t fill_line,
    output logic              fill_done
);
    import icache_pkg::*;

    localparam int BEAT_W = $clog2(`ICACHE_BEATS);
    localparam int WORD_W = $bits(word_t);

    logic [BEAT_W-1:0] beat_cnt;
    word_t             fill_buf [`ICACHE_BEATS];
    logic              beat;

    assign beat      = rvalid && rready;
    assign fill_done = beat && rlast;

    ////////////////////////////////////////
    // address and data handshakes

    always_ff @(posedge clk) begin
        if (!rst) begin
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            beat_cnt <= '0;
        end else if (start) begin
            arvalid  <= 1'b1;
            beat_cnt <= '0;
        end else begin
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (fill_done) begin
                rready <= 1'b0;
            end
            if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // line base, burst always starts at word 0
    always_ff @(posedge clk) begin
        if (start) begin
            araddr <= line_addr;
        end
    end

    ////////////////////////////////////////
    // fill buffer

    always_ff @(posedge clk) begin
        if (beat) begin
            fill_buf[beat_cnt] <= rdata;
        end
    end

    always_comb begin
        for (int k = 0; k < `ICACHE_BEATS; k++) begin
            fill_line[k*WORD_W +: WORD_W] = fill_buf[k];
        end
    end

endmodule

/* icache_ctrl.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_req,
    input  logic [`ICACHE_INDEX_W:0]  inst_index,
    input  icache_pkg::tag_t          inst_tag,
    output logic                      inst_index_ok,
    output logic                      inst_data_ok,
    output icache_pkg::half_t         inst_rdata,
    input  logic [`ICACHE_WAYS-1:0]   hit_way,
    input  icache_pkg::line_t         line0,
    input  icache_pkg::line_t         line1,
    input  icache_pkg::line_t         fill_line,
    input  logic                      fill_done,
    output logic                      refill_start,
    output icache_pkg::word_t         refill_addr,
    output icache_pkg::index_t        ram_index,
    output logic [`ICACHE_WAYS-1:0]   tag_we,
    output logic [`ICACHE_WAYS-1:0]   data_we,
    output icache_pkg::tag_t          wtag,
    output logic                      wvalid,
    output logic                      cmp_en,
    output logic                      hold
);
    import icache_pkg::*;

    localparam int OFFSET_W = $bits(word_t) - `ICACHE_TAG_W - `ICACHE_INDEX_W;
    localparam int HALF_W   = $bits(half_t);

    cache_state_t            state;
    index_t                  sweep_cnt;
    logic                    sta_req, sta_new, sta_half;
    index_t                  sta_index;
    tag_t                    sta_tag_q, cur_tag;
    logic                    sda_req, sda_half;
    index_t                  sda_index;
    tag_t                    sda_tag;
    logic [`ICACHE_SETS-1:0] lru;
    logic                    victim, adv, hit_any;
    logic [`ICACHE_WAYS-1:0] fill_way;
    line_t                   src_line;

    assign hit_any       = |hit_way;
    assign inst_data_ok  = sda_req && ((state == RUN && hit_any) || state == FINISH);
    // pipeline moves only in RUN, and only past an answered data stage
    assign adv           = (state == RUN) && (!sda_req || inst_data_ok);
    assign inst_index_ok = adv;
    assign cmp_en        = adv;
    assign hold          = !adv;
    assign cur_tag       = sta_new ? inst_tag : sta_tag_q;
    assign refill_start  = (state == RUN) && sda_req && !hit_any;
    assign refill_addr   = {sda_tag, sda_index, {OFFSET_W{1'b0}}};
    assign fill_way      = {victim, !victim};

    ////////////////////////////////////////
    // array control

    always_comb begin
        case (state)
            SWEEP:   ram_index = sweep_cnt;
            IDLE:    ram_index = sta_index;
            FINISH:  ram_index = sda_index;
            default: ram_index = inst_index[`ICACHE_INDEX_W:1];
        endcase
    end

    // tag bus doubles as the compare tag outside FINISH
    assign wtag    = (state == FINISH) ? sda_tag : cur_tag;
    assign wvalid  = (state != SWEEP);
    assign tag_we  = (state == SWEEP) ? '1 : (state == FINISH) ? fill_way : '0;
    assign data_we = (state == FINISH) ? fill_way : '0;

    assign src_line   = (state == FINISH) ? fill_line : (hit_way[1] ? line1 : line0);
    assign inst_rdata = sda_half ? src_line[2*HALF_W-1:HALF_W] : src_line[HALF_W-1:0];

    ////////////////////////////////////////
    // state machine and sweep

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= SWEEP;
            sweep_cnt <= '0;
        end else begin
            case (state)
                SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == index_t'(`ICACHE_RESET_CYCLES - 1)) begin
                        state <= IDLE;
                    end
                end
                IDLE:    state <= RUN;
                RUN:     state <= refill_start ? MISS : RUN;
                // refill_unit holds arvalid until arready
                MISS:    state <= REFILL;
                REFILL:  state <= fill_done ? FINISH : REFILL;
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // tag and data stages

    always_ff @(posedge clk) begin
        if (!rst) begin
            sta_req <= 1'b0;
            sta_new <= 1'b0;
            sda_req <= 1'b0;
        end else begin
            sta_new <= inst_req && inst_index_ok;
            if (adv) begin
                sta_req <= inst_req;
                sda_req <= sta_req;
            end else if (inst_data_ok) begin
                sda_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            sta_index <= inst_index[`ICACHE_INDEX_W:1];
            sta_half  <= inst_index[0];
            sda_index <= sta_index;
            sda_half  <= sta_half;
            sda_tag   <= cur_tag;
        end
        // tag is only driven the cycle after acceptance
        if (sta_new) begin
            sta_tag_q <= inst_tag;
        end
    end

    ////////////////////////////////////////
    // lru, one bit per set naming the recent way

    always_ff @(posedge clk) begin
        if (!rst) begin
            lru    <= '0;
            victim <= 1'b0;
        end else if (state == RUN && sda_req) begin
            if (hit_any) begin
                lru[sda_index] <= hit_way[1];
            end else begin
                victim <= !lru[sda_index];
            end
        end else if (state == FINISH) begin
            lru[sda_index] <= victim;
        end
    end

endmodule

/* icache_top.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_req,
    input  logic [`ICACHE_INDEX_W:0] inst_index,
    input  icache_pkg::tag_t         inst_tag,
    output logic                     inst_index_ok,
    output logic                     inst_data_ok,
    output icache_pkg::half_t        inst_rdata,
    output icache_pkg::word_t        araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  icache_pkg::word_t        rdata,
    input  logic                     rvalid,
    input  logic                     rlast,
    output logic                     rready
);
    import icache_pkg::*;

    index_t                  ram_index;
    logic [`ICACHE_WAYS-1:0] tag_we, data_we, hit_way;
    tag_t                    wtag;
    logic                    wvalid, cmp_en, hold;
    line_t                   line0, line1, fill_line;
    logic                    fill_done, refill_start;
    word_t                   refill_addr;

    tag_lookup u_tag (
        .clk    (clk),
        .rst    (rst),
        .index  (ram_index),
        .we     (tag_we),
        .wtag   (wtag),
        .wvalid (wvalid),
        .cmp_tag(wtag),
        .cmp_en (cmp_en),
        .hit_way(hit_way)
    );

    data_lookup u_data (
        .clk  (clk),
        .index(ram_index),
        .we   (data_we),
        .wline(fill_line),
        .hold (hold),
        .line0(line0),
        .line1(line1)
    );

    refill_unit u_refill (
        .clk(clk), .rst(rst), .start(refill_start), .line_addr(refill_addr),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready),
        .fill_line(fill_line), .fill_done(fill_done)
    );

    icache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_index(inst_index),
        .inst_tag(inst_tag), .inst_index_ok(inst_index_ok),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .hit_way(hit_way), .line0(line0), .line1(line1),
        .fill_line(fill_line), .fill_done(fill_done),
        .refill_start(refill_start), .refill_addr(refill_addr),
        .ram_index(ram_index), .tag_we(tag_we), .data_we(data_we),
        .wtag(wtag), .wvalid(wvalid), .cmp_en(cmp_en), .hold(hold)
    );

endmodule

/* icache_checker.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_req,
    input  logic [`ICACHE_INDEX_W:0] inst_index,
    input  icache_pkg::tag_t         inst_tag,
    input  logic                     inst_index_ok,
    input  logic                     inst_data_ok,
    input  icache_pkg::half_t        inst_rdata,
    input  icache_pkg::word_t        araddr,
    input  logic                     arvalid,
    input  logic                     arready,
    input  logic                     rvalid,
    input  logic                     rready,
    output int                       errors,
    output int                       checks,
    output int                       responses,
    output int                       hits
);
    import icache_pkg::*;

    typedef struct {
        index_t set;
        logic   half;
        tag_t   tag;
        logic   hit;
        int     t_acc;
    } pending_t;

    pending_t q[$];
    tag_t     mtag [`ICACHE_SETS][`ICACHE_WAYS];
    logic     mval [`ICACHE_SETS][`ICACHE_WAYS];
    logic     mlru [`ICACHE_SETS];
    int       cyc, ok_cycle, ar_cnt, beat_cnt, last_resp;
    logic     tag_due, last_miss;

    // same address mixing rule as the memory model
    function automatic word_t line_word(input word_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h0F0F_5A5A;
    endfunction

    function automatic half_t expect_half(input tag_t t, input index_t s, input logic h);
        word_t base;
        half_t v;
        base = {t, s, 5'b0};
        for (int k = 0; k < 4; k++) begin
            v[k*32 +: 32] = line_word(base + word_t'(h ? 16 : 0) + word_t'(4 * k));
        end
        return v;
    endfunction

    initial begin
        errors = 0;
        checks = 0;
        responses = 0;
        hits = 0;
        ok_cycle = 0;
        ar_cnt = 0;
        beat_cnt = 0;
        last_resp = 0;
        last_miss = 1'b0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            mval[s][0] = 1'b0;
            mval[s][1] = 1'b0;
            mlru[s] = 1'b0;
        end
    end

    always @(negedge clk) begin
        pending_t r;
        half_t    exp;
        index_t   s;
        logic     v;
        int       last;
        int       exp_cyc;
        if (!rst) begin
            cyc = 0;
            tag_due = 1'b0;
        end else begin
            cyc++;
            ////////////////////////////////////////
            // reset sweep window
            if (ok_cycle == 0 && inst_index_ok) begin
                ok_cycle = cyc;
                checks++;
                if (cyc != `ICACHE_RESET_CYCLES + 2) begin
                    $display("ERROR t=%0t inst_index_ok first high cycle: got %0d expected %0d",
                             $time, cyc, `ICACHE_RESET_CYCLES + 2);
                    errors++;
                end
            end
            if (ok_cycle == 0 && (inst_data_ok || arvalid)) begin
                $display("cache answered or refilled during the reset sweep at %0t", $time);
                errors++;
            end
            // tag arrives one cycle after acceptance, predict with the LRU model
            if (tag_due) begin
                last = q.size() - 1;
                s = q[last].set;
                q[last].tag = inst_tag;
                if (mval[s][0] && mtag[s][0] == inst_tag) begin
                    q[last].hit = 1'b1;
                    mlru[s] = 1'b0;
                end else if (mval[s][1] && mtag[s][1] == inst_tag) begin
                    q[last].hit = 1'b1;
                    mlru[s] = 1'b1;
                end else begin
                    v = !mlru[s];
                    q[last].hit = 1'b0;
                    mtag[s][v] = inst_tag;
                    mval[s][v] = 1'b1;
                    mlru[s] = v;
                end
                tag_due = 1'b0;
            end
            if (arvalid && arready) begin
                ar_cnt++;
                if (q.size() == 0) begin
                    $display("AR handshake at %0t with no request outstanding", $time);
                    errors++;
                end else if (araddr != {q[0].tag, q[0].set, 5'b0}) begin
                    $display("ERROR t=%0t araddr: got %h expected %h",
                             $time, araddr, {q[0].tag, q[0].set, 5'b0});
                    errors++;
                end
            end
            if (rvalid && rready) begin
                beat_cnt++;
            end
            ////////////////////////////////////////
            // response checks
            if (inst_data_ok) begin
                if (q.size() == 0) begin
                    $display("inst_data_ok at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    r = q.pop_front();
                    exp = expect_half(r.tag, r.set, r.half);
                    checks++;
                    if (inst_rdata !== exp) begin
                        $display("ERROR t=%0t inst_rdata: got %h expected %h",
                                 $time, inst_rdata, exp);
                        errors++;
                    end
                    if (ar_cnt == 0) begin
                        hits++;
                    end
                    if (r.hit) begin
                        // held in the tag stage behind a miss, answered after the IDLE reread
                        exp_cyc = r.t_acc + 2;
                        if (last_miss && last_resp + 3 > exp_cyc) begin
                            exp_cyc = last_resp + 3;
                        end
                        if (cyc != exp_cyc) begin
                            $display("ERROR t=%0t inst_data_ok latency: got %0d expected %0d",
                                     $time, cyc - r.t_acc, exp_cyc - r.t_acc);
                            errors++;
                        end
                        if (ar_cnt != 0) begin
                            $display("refill issued for a predicted hit on set %0d at %0t",
                                     r.set, $time);
                            errors++;
                        end
                    end else if (ar_cnt != 1 || beat_cnt != `ICACHE_BEATS) begin
                        $display("miss on set %0d made %0d AR handshakes and %0d beats",
                                 r.set, ar_cnt, beat_cnt);
                        errors++;
                    end
                    last_resp = cyc;
                    last_miss = !r.hit;
                end
                ar_cnt = 0;
                beat_cnt = 0;
                responses++;
            end
            if (inst_req && inst_index_ok) begin
                r.set = inst_index[`ICACHE_INDEX_W:1];
                r.half = inst_index[0];
                r.tag = '0;
                r.hit = 1'b0;
                r.t_acc = cyc;
                q.push_back(r);
                tag_due = 1'b1;
            end
        end
    end

endmodule

/* tb_icache.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_icache;
    import icache_pkg::*;

    localparam int N_RANDOM    = 60;
    localparam int N_TOTAL     = 1 + 6 + N_RANDOM;
    localparam int CYCLE_LIMIT = N_TOTAL * 200 + `ICACHE_RESET_CYCLES + 10;

    logic                     clk, rst, inst_req;
    logic [`ICACHE_INDEX_W:0] inst_index;
    tag_t                     inst_tag;
    logic                     inst_index_ok, inst_data_ok;
    half_t                    inst_rdata;
    word_t                    araddr, rdata;
    logic                     arvalid, arready, rvalid, rlast, rready;
    int                       errors, checks, responses, hits;
    int                       sent, local_errors, h0;
    int                       cycles = 0;
    logic [31:0]              rng, axi_rng;
    index_t                   set_pool [4] = '{7'd3, 7'd17, 7'd64, 7'd127};
    tag_t                     tag_pool [4] = '{20'h00A11, 20'h0B222, 20'hC0333, 20'hFD444};

    icache_top DUT (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_index(inst_index),
        .inst_tag(inst_tag), .inst_index_ok(inst_index_ok),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready)
    );

    icache_checker u_checker (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_index(inst_index),
        .inst_tag(inst_tag), .inst_index_ok(inst_index_ok),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready),
        .errors(errors), .checks(checks), .responses(responses), .hits(hits)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d responses", cycles, responses, sent);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t mem_word(input word_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h0F0F_5A5A;
    endfunction

    // hold the request until accepted, then give its tag one cycle
    task send_request(input index_t set, input logic half, input tag_t tag);
        inst_req = 1'b1;
        inst_index = {set, half};
        do @(negedge clk); while (!inst_index_ok);
        @(posedge clk);
        #2;
        inst_tag = tag;
        inst_req = 1'b0;
        sent++;
    endtask

    task end_test(input string name, input int chk0, input int err0);
        while (responses != sent) @(negedge clk);
        $display("test %s: %0d checks, %0d errors", name, checks - chk0,
                 errors + local_errors - err0);
    endtask

    ////////////////////////////////////////
    // AXI read memory
    initial begin
        word_t base;
        int    delay;
        axi_rng = 32'd15275;
        @(posedge rst);
        forever begin
            do @(negedge clk); while (!arvalid);
            axi_rng = xorshift(axi_rng);
            delay = axi_rng % 4;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            #2;
            arready = 1'b1;
            base = araddr;
            @(posedge clk);
            #2;
            arready = 1'b0;
            for (int k = 0; k < `ICACHE_BEATS; k++) begin
                rdata = mem_word(base + word_t'(4 * k));
                rvalid = 1'b1;
                rlast = (k == `ICACHE_BEATS - 1);
                do @(negedge clk); while (!rready);
                @(posedge clk);
                #2;
            end
            rvalid = 1'b0;
            rlast = 1'b0;
        end
    end

    initial begin
        int c0;
        int e0;
        rng = 32'd15275;
        rst = 1'b0;
        inst_req = 1'b0;
        inst_index = '0;
        inst_tag = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        rdata = '0;
        sent = 0;
        local_errors = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b1;

        c0 = checks;
        e0 = errors;
        h0 = hits;
        send_request(7'd5, 1'b0, 20'h00012);
        end_test("sweep and first miss", c0, e0);
        if (hits != h0) begin
            $display("first request after the sweep did not miss");
            local_errors++;
        end

        // A, B, A, C on one set, then A and B again
        c0 = checks;
        e0 = errors + local_errors;
        h0 = hits;
        send_request(7'd9, 1'b0, 20'hA0001);
        send_request(7'd9, 1'b1, 20'hB0002);
        send_request(7'd9, 1'b1, 20'hA0001);
        send_request(7'd9, 1'b0, 20'hC0003);
        send_request(7'd9, 1'b0, 20'hA0001);
        send_request(7'd9, 1'b1, 20'hB0002);
        end_test("lru sequence", c0, e0);
        if (hits - h0 != 2) begin
            $display("lru sequence gave %0d hits instead of 2", hits - h0);
            local_errors++;
        end

        c0 = checks;
        e0 = errors + local_errors;
        for (int n = 0; n < N_RANDOM; n++) begin
            rng = xorshift(rng);
            send_request(set_pool[rng[1:0]], rng[4], tag_pool[rng[3:2]]);
            if (rng[7:5] == 3'd0) begin
                @(posedge clk);
                #2;
            end
        end
        end_test("random", c0, e0);

        $display("%0d checks, %0d errors", checks, errors + local_errors);
        if (errors + local_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
icache_pkg.sv
way_ram.sv
tag_lookup.sv
data_lookup.sv
refill_unit.sv
icache_ctrl.sv
icache_top.sv
icache_checker.sv
tb_icache.sv
